// File: filelist.f
+incdir+.
rv_pkg.sv
rv_idu.sv
rv_regfile.sv
rv_ifu.sv
rv_alu.sv
rv_bjp.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv

// File: tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// instruction kinds made by the generator
localparam int K_ALU  = 0;
localparam int K_BJP  = 1;
localparam int K_LD   = 2;
localparam int K_ST   = 3;
localparam int K_EBRK = 4;
localparam int K_BAD  = 5;

// architectural state
logic [63:0] m_rf [32];
logic [63:0] m_pc;
logic [7:0]  dmem [logic [63:0]];
logic [31:0] imem [logic [63:0]];
int          kmem [logic [63:0]];

// expected effects of the instruction on the fetch port
logic [31:0] e_inst;
int          e_kind;
logic        e_wb_en;
logic [4:0]  e_rd;
logic [63:0] e_wb_data;
logic [63:0] e_next_pc;
logic [63:0] e_addr;
logic [63:0] e_wdata;
logic [63:0] e_rdata;
logic [7:0]  e_mask;

// random legal instruction, x31 never written so it stays a fixed base
function automatic logic [31:0] gen_inst(output int kind);
  int unsigned r;
  int unsigned sel;
  logic        alt;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  base;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [12:0] boff;
  logic [20:0] joff;
  r    = $urandom_range(99);
  sel  = $urandom_range(5);
  alt  = 1'($urandom_range(1));
  rd   = 5'($urandom_range(30));
  rs1  = 5'($urandom_range(31));
  rs2  = 5'($urandom_range(31));
  base = alt ? 5'd31 : 5'd0;
  f3   = 3'($urandom);
  imm  = 12'($urandom);
  // forward only, nonzero and word aligned
  boff = 13'($urandom_range(1, 1023) << 2);
  joff = 21'($urandom_range(1, 262143) << 2);
  kind = K_ALU;
  if (r < 5) begin
    kind = K_BAD;
    // opcode bits 1..0 of 00 match no group
    return $urandom & 32'hffff_fffc;
  end else if (r < 7) begin
    kind = K_EBRK;
    return 32'h0010_0073;
  end else if (r < 12) begin
    kind = K_BJP;
    f3 = 3'(sel < 2 ? sel : sel + 2);
    return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'h63};
  end else if (r < 14) begin
    kind = K_BJP;
    return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
  end else if (r < 16) begin
    kind = K_BJP;
    return {imm[11:2], 2'b00, base, 3'd0, rd, 7'h67};
  end else if (r < 24) begin
    kind = K_LD;
    f3 = 3'($urandom_range(6));
    imm = imm & (12'hfff << f3[1:0]);
    return {imm, base, f3, rd, 7'h03};
  end else if (r < 32) begin
    kind = K_ST;
    f3 = {1'b0, f3[1:0]};
    imm = imm & (12'hfff << f3[1:0]);
    return {imm[11:5], rs2, base, f3, imm[4:0], 7'h23};
  end
  case (sel)
    0: return {((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
    1: begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {(f3 == 3'd5 && alt) ? 6'h10 : 6'h00, imm[5:0]};
      end
      return {imm, rs1, f3, rd, 7'h13};
    end
    2: begin
      f3 = (f3 < 3) ? 3'd0 : (f3 < 5) ? 3'd1 : 3'd5;
      return {(f3 != 3'd1 && alt) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h3b};
    end
    3: begin
      f3 = (f3 < 3) ? 3'd0 : (f3 < 5) ? 3'd1 : 3'd5;
      if (f3 != 3'd0) begin
        imm = {(f3 == 3'd5 && alt) ? 7'h20 : 7'h00, imm[4:0]};
      end
      return {imm, rs1, f3, rd, 7'h1b};
    end
    4: return {imm, rs1, f3, rd, 7'h37};
    default: return {imm, rs1, f3, rd, 7'h17};
  endcase
endfunction

function automatic logic [63:0] alu64(logic [2:0] f3, logic alt, logic [63:0] a,
                                      logic [63:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[5:0];
    3'd2: return {63'd0, $signed(a) < $signed(b)};
    3'd3: return {63'd0, a < b};
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[5:0];
      end
      return a >> b[5:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [63:0] alu32(logic [2:0] f3, logic alt, logic [31:0] a,
                                      logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    default: begin
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
  endcase
  return {{32{r[31]}}, r};
endfunction

// aligned little-endian doubleword around addr
function automatic logic [63:0] read_lane(logic [63:0] addr);
  logic [63:0] lane;
  logic [63:0] ba;
  for (int k = 0; k < 8; k++) begin
    ba = {addr[63:3], 3'(k)};
    // untouched bytes come up random
    if (!dmem.exists(ba)) begin
      dmem[ba] = 8'($urandom);
    end
    lane[8*k +: 8] = dmem[ba];
  end
  return lane;
endfunction

task automatic init_model();
  for (int i = 0; i < 32; i++) begin
    m_rf[i] = '0;
  end
  m_pc = `RESET_PC;
  // lui x31, 0x10000 gives the aligned base for loads, stores and jalr
  imem[`RESET_PC] = {20'h10000, 5'd31, 7'h37};
  kmem[`RESET_PC] = K_ALU;
endtask

task automatic predict_next();
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] ii;
  logic [63:0] sh;
  logic [2:0]  f3;
  logic        wr;
  logic        take;
  int          kind;
  if (!imem.exists(m_pc)) begin
    imem[m_pc] = gen_inst(kind);
    kmem[m_pc] = kind;
  end
  e_inst    = imem[m_pc];
  e_kind    = kmem[m_pc];
  e_rd      = e_inst[11:7];
  f3        = e_inst[14:12];
  a         = m_rf[e_inst[19:15]];
  b         = m_rf[e_inst[24:20]];
  ii        = {{52{e_inst[31]}}, e_inst[31:20]};
  wr        = 1'b0;
  e_wb_data = '0;
  e_next_pc = m_pc + 64'd4;
  e_addr    = '0;
  e_wdata   = '0;
  e_mask    = '0;
  e_rdata   = {$urandom, $urandom};
  case (e_inst[6:0])
    7'h33: begin
      wr = 1'b1;
      e_wb_data = alu64(f3, e_inst[30], a, b);
    end
    7'h13: begin
      wr = 1'b1;
      e_wb_data = alu64(f3, e_inst[30] && f3 == 3'd5, a, ii);
    end
    7'h3b: begin
      wr = 1'b1;
      e_wb_data = alu32(f3, e_inst[30], a[31:0], b[31:0]);
    end
    7'h1b: begin
      wr = 1'b1;
      e_wb_data = alu32(f3, e_inst[30] && f3 == 3'd5, a[31:0], ii[31:0]);
    end
    7'h37: begin
      wr = 1'b1;
      e_wb_data = {{32{e_inst[31]}}, e_inst[31:12], 12'h000};
    end
    7'h17: begin
      wr = 1'b1;
      e_wb_data = m_pc + {{32{e_inst[31]}}, e_inst[31:12], 12'h000};
    end
    7'h6f: begin
      wr = 1'b1;
      e_wb_data = m_pc + 64'd4;
      e_next_pc = m_pc + {{43{e_inst[31]}}, e_inst[31], e_inst[19:12], e_inst[20],
                          e_inst[30:21], 1'b0};
    end
    7'h67: begin
      wr = 1'b1;
      e_wb_data = m_pc + 64'd4;
      e_next_pc = (a + ii) & ~64'd1;
    end
    7'h63: begin
      case (f3)
        3'd0: take = a == b;
        3'd1: take = a != b;
        3'd4: take = $signed(a) < $signed(b);
        3'd5: take = $signed(a) >= $signed(b);
        3'd6: take = a < b;
        default: take = a >= b;
      endcase
      if (take) begin
        e_next_pc = m_pc + {{51{e_inst[31]}}, e_inst[31], e_inst[7], e_inst[30:25],
                            e_inst[11:8], 1'b0};
      end
    end
    7'h03: begin
      wr = 1'b1;
      e_addr = a + ii;
      e_rdata = read_lane(e_addr);
      sh = e_rdata >> {e_addr[2:0], 3'b000};
      case (f3)
        3'd0: e_wb_data = {{56{sh[7]}}, sh[7:0]};
        3'd1: e_wb_data = {{48{sh[15]}}, sh[15:0]};
        3'd2: e_wb_data = {{32{sh[31]}}, sh[31:0]};
        3'd4: e_wb_data = {56'd0, sh[7:0]};
        3'd5: e_wb_data = {48'd0, sh[15:0]};
        3'd6: e_wb_data = {32'd0, sh[31:0]};
        default: e_wb_data = sh;
      endcase
    end
    7'h23: begin
      e_addr = a + {{52{e_inst[31]}}, e_inst[31:25], e_inst[11:7]};
      e_mask = 8'(((1 << (1 << f3[1:0])) - 1) << e_addr[2:0]);
      e_wdata = b << {e_addr[2:0], 3'b000};
    end
    default: wr = 1'b0;
  endcase
  e_wb_en = wr && e_rd != 5'd0;
endtask

task automatic retire();
  if (e_wb_en) begin
    m_rf[e_rd] = e_wb_data;
  end
  for (int k = 0; k < 8; k++) begin
    if (e_mask[k]) begin
      dmem[{e_addr[63:3], 3'(k)}] = e_wdata[8*k +: 8];
    end
  end
  m_pc = e_next_pc;
endtask

`endif

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module tb_rv_core;

  localparam int N_ALU      = 2000;
  localparam int MAX_CYCLES = 8 * N_ALU + 50;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] inst;
  logic [63:0] mem_rdata;
  logic [63:0] inst_addr, mem_addr, mem_wdata, commit_pc, commit_wb_data;
  logic        mem_rd_en, mem_wr_en, commit_valid, commit_wb_en, ebreak, invalid_inst;
  logic [7:0]  mem_wmask;
  logic [31:0] commit_inst;
  logic [4:0]  commit_wb_idx;

  int errs [1:6] = '{default: 0};
  int n_ok = 0;
  int n_bad = 0;
  int cycles = 0;

  `include "tb_rv_model.svh"

  rv_core dut0 (
    .clk_i(clk), .rst_n_i(rst_n), .inst_addr_o(inst_addr), .inst_i(inst),
    .mem_addr_o(mem_addr), .mem_rd_en_o(mem_rd_en), .mem_wr_en_o(mem_wr_en),
    .mem_wmask_o(mem_wmask), .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata),
    .commit_valid_o(commit_valid), .commit_pc_o(commit_pc), .commit_inst_o(commit_inst),
    .commit_wb_en_o(commit_wb_en), .commit_wb_idx_o(commit_wb_idx),
    .commit_wb_data_o(commit_wb_data), .ebreak_o(ebreak), .invalid_inst_o(invalid_inst)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the core did not retire %0d alu instructions in %0d cycles",
               N_ALU, cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(input int t, input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp) begin
      errs[t]++;
      $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_reset_state();
    check_value(1, "inst_addr_o", `RESET_PC, inst_addr);
    check_value(1, "commit_valid_o", 0, commit_valid);
    check_value(1, "mem_wr_en_o", 0, mem_wr_en);
    check_value(1, "mem_rd_en_o", 0, mem_rd_en);
  endtask

  task automatic check_commit();
    logic [63:0] bm;
    int          t;
    for (int k = 0; k < 8; k++) begin
      bm[8*k +: 8] = {8{e_mask[k]}};
    end
    // behavior that owns this kind of instruction
    t = (e_kind == K_ALU) ? 2 : (e_kind == K_BJP) ? 3 : (e_kind == K_ST) ? 4 :
        (e_kind == K_LD) ? 5 : 6;
    check_value(3, "inst_addr_o", m_pc, inst_addr);
    check_value(3, "commit_pc_o", m_pc, commit_pc);
    check_value(t, "commit_valid_o", 1, commit_valid);
    check_value(t, "commit_inst_o", e_inst, commit_inst);
    check_value(t, "commit_wb_en_o", e_wb_en, commit_wb_en);
    if (e_wb_en) begin
      check_value(t, "commit_wb_idx_o", e_rd, commit_wb_idx);
      check_value(t, "commit_wb_data_o", e_wb_data, commit_wb_data);
    end
    check_value(4, "mem_wr_en_o", e_kind == K_ST, mem_wr_en);
    check_value(5, "mem_rd_en_o", e_kind == K_LD, mem_rd_en);
    check_value(6, "invalid_inst_o", e_kind == K_BAD, invalid_inst);
    check_value(6, "ebreak_o", e_kind == K_EBRK, ebreak);
    if (e_kind == K_ST || e_kind == K_LD) begin
      check_value(t, "mem_addr_o", e_addr, mem_addr);
    end
    if (e_kind == K_ST) begin
      check_value(4, "mem_wmask_o", e_mask, mem_wmask);
      check_value(4, "mem_wdata_o", e_wdata & bm, mem_wdata & bm);
    end
  endtask

  task automatic report_behavior(input int t, input string what);
    if (errs[t] == 0) begin
      n_ok++;
    end else begin
      n_bad++;
    end
    $display("behavior %0d %s: %s, %0d mismatches", t, what,
             errs[t] == 0 ? "ok" : "FAILED", errs[t]);
  endtask

  initial begin
    int alu_done;
    alu_done = 0;
    void'($urandom(99));
    init_model();
    predict_next();
    rst_n     <= 1'b0;
    inst      <= e_inst;
    mem_rdata <= e_rdata;
    repeat (8) begin
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    // running is still low until the next edge
    @(negedge clk);
    check_reset_state();
    report_behavior(1, "reset");
    @(posedge clk);
    while (alu_done < N_ALU) begin
      @(negedge clk);
      check_commit();
      if (e_kind == K_ALU) begin
        alu_done++;
      end
      @(posedge clk);
      retire();
      predict_next();
      inst      <= e_inst;
      mem_rdata <= e_rdata;
    end
    report_behavior(2, "alu and immediates");
    report_behavior(3, "branches and jumps");
    report_behavior(4, "stores");
    report_behavior(5, "loads");
    report_behavior(6, "status");
    $display("%0d behaviors ok, %0d failing", n_ok, n_bad);
    if (n_bad == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  output logic [`XLEN-1:0] inst_addr_o,
  input  logic [31:0]      inst_i,
  output logic [`XLEN-1:0] mem_addr_o,
  output logic             mem_rd_en_o,
  output logic             mem_wr_en_o,
  output logic [7:0]       mem_wmask_o,
  output logic [`XLEN-1:0] mem_wdata_o,
  input  logic [`XLEN-1:0] mem_rdata_i,
  output logic             commit_valid_o,
  output logic [`XLEN-1:0] commit_pc_o,
  output logic [31:0]      commit_inst_o,
  output logic             commit_wb_en_o,
  output logic [4:0]       commit_wb_idx_o,
  output logic [`XLEN-1:0] commit_wb_data_o,
  output logic             ebreak_o,
  output logic             invalid_inst_o
);

  logic [`XLEN-1:0] pc, target, alu_result, load_data, wb_data;
  logic [`XLEN-1:0] op1, op2, op1_jp, op2_jp, rs1_data, rs2_data;
  logic [4:0]       rd_idx, rs1_idx, rs2_idx;
  logic             running, redirect, rd_wr_en, rs1_ren, rs2_ren, wb_en;
  exu_info_t        exu_info;

  rv_ifu u_ifu (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .redirect_i(redirect), .target_i(target),
    .pc_o(pc), .running_o(running)
  );

  rv_idu u_idu (
    .inst_i(inst_i), .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rd_wr_en_o(rd_wr_en), .rs1_read_en_o(rs1_ren), .rs2_read_en_o(rs2_ren),
    .rd_idx_o(rd_idx), .rs1_idx_o(rs1_idx), .rs2_idx_o(rs2_idx),
    .op1_o(op1), .op2_o(op2), .op1_jp_o(op1_jp), .op2_jp_s_o(op2_jp),
    .exu_info_o(exu_info), .invalid_inst_o(invalid_inst_o)
  );

  // unread ports look up x0
  rv_regfile u_regfile (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .rs1_idx_i({5{rs1_ren}} & rs1_idx), .rs2_idx_i({5{rs2_ren}} & rs2_idx),
    .wr_en_i(wb_en), .wr_idx_i(rd_idx), .wr_data_i(wb_data),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  rv_alu u_alu (.op1_i(op1), .op2_i(op2), .exu_info_i(exu_info), .result_o(alu_result));

  rv_bjp u_bjp (
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .base_i(op1_jp), .offset_i(op2_jp),
    .exu_info_i(exu_info), .redirect_o(redirect), .target_o(target)
  );

  rv_lsu u_lsu (
    .base_i(op1_jp), .offset_i(op2_jp), .rs2_data_i(rs2_data), .exu_info_i(exu_info),
    .running_i(running), .mem_rdata_i(mem_rdata_i), .mem_addr_o(mem_addr_o),
    .mem_rd_en_o(mem_rd_en_o), .mem_wr_en_o(mem_wr_en_o), .mem_wmask_o(mem_wmask_o),
    .mem_wdata_o(mem_wdata_o), .load_data_o(load_data)
  );

  // writeback select
  assign wb_en   = running & rd_wr_en;
  assign wb_data = ((exu_info.ls.sel == `EXU_SEL_LS) && exu_info.ls.load) ? load_data
                                                                          : alu_result;

  assign inst_addr_o      = pc;
  assign commit_valid_o   = running;
  assign commit_pc_o      = pc;
  assign commit_inst_o    = inst_i;
  assign commit_wb_en_o   = wb_en;
  assign commit_wb_idx_o  = rd_idx;
  assign commit_wb_data_o = wb_data;

  assign ebreak_o = (exu_info.alu.sel == `EXU_SEL_ALU) & exu_info.alu.ebreak;

endmodule

`default_nettype wire

// File: rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_lsu
  import rv_pkg::*;
(
  input  logic [`XLEN-1:0] base_i,
  input  logic [`XLEN-1:0] offset_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  input  exu_info_t        exu_info_i,
  input  logic             running_i,
  input  logic [`XLEN-1:0] mem_rdata_i,
  output logic [`XLEN-1:0] mem_addr_o,
  output logic             mem_rd_en_o,
  output logic             mem_wr_en_o,
  output logic [7:0]       mem_wmask_o,
  output logic [`XLEN-1:0] mem_wdata_o,
  output logic [`XLEN-1:0] load_data_o
);

  ls_info_t l;
  logic     ld;
  logic     st;
  logic [7:0] size_mask;
  logic [`XLEN-1:0] rdata_sh;
  logic     misalign;

  assign l  = exu_info_i.ls;
  assign ld = (l.sel == `EXU_SEL_LS) & l.load;
  assign st = (l.sel == `EXU_SEL_LS) & l.store;

  assign mem_addr_o  = base_i + offset_i;
  assign mem_rd_en_o = running_i & ld;
  assign mem_wr_en_o = running_i & st;

  wire [2:0] lane    = mem_addr_o[2:0];
  wire [5:0] bit_off = {lane, 3'b000};

  // byte lanes of an aligned little-endian doubleword
  assign size_mask = ({8{l.sz_byte}}  & 8'h01) |
                     ({8{l.sz_half}}  & 8'h03) |
                     ({8{l.sz_word}}  & 8'h0f) |
                     ({8{l.sz_dword}} & 8'hff);

  assign mem_wmask_o = {8{st}} & (size_mask << lane);
  assign mem_wdata_o = rs2_data_i << bit_off;

  // load extract and extend
  assign rdata_sh = mem_rdata_i >> bit_off;

  wire sx = ~l.usign;

  assign load_data_o =
    ({64{l.sz_byte}}  & {{56{sx & rdata_sh[7]}},  rdata_sh[7:0]})  |
    ({64{l.sz_half}}  & {{48{sx & rdata_sh[15]}}, rdata_sh[15:0]}) |
    ({64{l.sz_word}}  & {{32{sx & rdata_sh[31]}}, rdata_sh[31:0]}) |
    ({64{l.sz_dword}} & rdata_sh);

  assign misalign = (l.sz_half & lane[0]) |
                    (l.sz_word & (lane[1:0] != 2'b00)) |
                    (l.sz_dword & (lane != 3'b000));

  always_comb begin
    assert final (!(running_i && (ld || st)) || !misalign);
  end

endmodule

`default_nettype wire

// File: rv_bjp.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_bjp
  import rv_pkg::*;
(
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  input  logic [`XLEN-1:0] base_i,
  input  logic [`XLEN-1:0] offset_i,
  input  exu_info_t        exu_info_i,
  output logic             redirect_o,
  output logic [`XLEN-1:0] target_o
);

  bjp_info_t b;
  logic      bjp_sel;
  logic      eq;
  logic      lt;
  logic      ltu;
  logic      taken;
  logic [`XLEN-1:0] sum;

  assign b       = exu_info_i.bjp;
  assign bjp_sel = b.sel == `EXU_SEL_BJP;

  // register compare
  assign eq  = rs1_data_i == rs2_data_i;
  assign lt  = $signed(rs1_data_i) < $signed(rs2_data_i);
  assign ltu = rs1_data_i < rs2_data_i;

  assign taken = (b.beq & eq) | (b.bne & ~eq) | (b.blt & lt) | (b.bge & ~lt) |
                 (b.bltu & ltu) | (b.bgeu & ~ltu);

  assign redirect_o = bjp_sel & (taken | b.jal | b.jalr);

  // jalr clears bit 0 of the target
  assign sum      = base_i + offset_i;
  assign target_o = {sum[`XLEN-1:1], sum[0] & ~(bjp_sel & b.jalr)};

endmodule

`default_nettype wire

// File: rv_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_alu
  import rv_pkg::*;
(
  input  logic [`XLEN-1:0] op1_i,
  input  logic [`XLEN-1:0] op2_i,
  input  exu_info_t        exu_info_i,
  output logic [`XLEN-1:0] result_o
);

  alu_info_t  a;
  logic       alu_sel;
  logic       link;
  logic [31:0] res_w;
  logic [`XLEN-1:0] res_d;

  assign a       = exu_info_i.alu;
  assign alu_sel = a.sel == `EXU_SEL_ALU;
  // jal and jalr write pc + 4 through the adder
  assign link    = (exu_info_i.bjp.sel == `EXU_SEL_BJP) &
                   (exu_info_i.bjp.jal | exu_info_i.bjp.jalr);

  wire do_add = (alu_sel & a.add) | link;
  wire do_sub = alu_sel & a.sub;
  wire do_sll = alu_sel & a.sll;
  wire do_srl = alu_sel & a.srl;
  wire do_sra = alu_sel & a.sra;

  wire [5:0]  shamt = op2_i[5:0];
  wire [31:0] op1_w = op1_i[31:0];
  wire [31:0] op2_w = op2_i[31:0];

  // full width results
  always_comb begin
    res_d = ({64{do_add}} & (op1_i + op2_i)) |
            ({64{do_sub}} & (op1_i - op2_i)) |
            ({64{do_sll}} & (op1_i << shamt)) |
            ({64{do_srl}} & (op1_i >> shamt)) |
            ({64{do_sra}} & `XLEN'($signed(op1_i) >>> shamt)) |
            ({64{alu_sel & a.slt}}  & `XLEN'($signed(op1_i) < $signed(op2_i))) |
            ({64{alu_sel & a.sltu}} & `XLEN'(op1_i < op2_i)) |
            ({64{alu_sel & a.xor_}} & (op1_i ^ op2_i)) |
            ({64{alu_sel & a.or_}}  & (op1_i | op2_i)) |
            ({64{alu_sel & a.and_}} & (op1_i & op2_i)) |
            ({64{alu_sel & a.lui}}  & op2_i);
  end

  // word results with 5-bit shift amounts
  always_comb begin
    res_w = ({32{do_add}} & (op1_w + op2_w)) |
            ({32{do_sub}} & (op1_w - op2_w)) |
            ({32{do_sll}} & (op1_w << op2_i[4:0])) |
            ({32{do_srl}} & (op1_w >> op2_i[4:0])) |
            ({32{do_sra}} & 32'($signed(op1_w) >>> op2_i[4:0]));
  end

  // ebreak sets no operation flag and so gives zero
  assign result_o = (alu_sel & a.wop) ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

`default_nettype wire

// File: rv_ifu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_ifu (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             redirect_i,
  input  logic [`XLEN-1:0] target_i,
  output logic [`XLEN-1:0] pc_o,
  output logic             running_o
);

  wire [`XLEN-1:0] next_pc = redirect_i ? target_i : pc_o + `XLEN'd4;

  // first edge after reset only sets running
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o      <= `RESET_PC;
      running_o <= 1'b0;
    end else begin
      running_o <= 1'b1;
      if (running_o) begin
        pc_o <= next_pc;
      end
    end
  end

  a_pc_align: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_regfile (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [4:0]       rs1_idx_i,
  input  logic [4:0]       rs2_idx_i,
  input  logic             wr_en_i,
  input  logic [4:0]       wr_idx_i,
  input  logic [`XLEN-1:0] wr_data_i,
  output logic [`XLEN-1:0] rs1_data_o,
  output logic [`XLEN-1:0] rs2_data_o
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != 5'd0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  // x0 is never written, so it reads its reset zero
  assign rs1_data_o = regs[rs1_idx_i];
  assign rs2_data_o = regs[rs2_idx_i];

  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i) regs[0] == '0);

endmodule

`default_nettype wire

// File: rv_idu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_idu
  import rv_pkg::*;
(
  input  logic [31:0]      inst_i,
  input  logic [`XLEN-1:0] pc_i,
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  output logic             rd_wr_en_o,
  output logic             rs1_read_en_o,
  output logic             rs2_read_en_o,
  output logic [4:0]       rd_idx_o,
  output logic [4:0]       rs1_idx_o,
  output logic [4:0]       rs2_idx_o,
  output logic [`XLEN-1:0] op1_o,
  output logic [`XLEN-1:0] op2_o,
  output logic [`XLEN-1:0] op1_jp_o,
  output logic [`XLEN-1:0] op2_jp_s_o,
  output exu_info_t        exu_info_o,
  output logic             invalid_inst_o
);

  wire [6:0] opcode = inst_i[6:0];
  wire [6:0] funct7 = inst_i[31:25];
  wire [7:0] f3     = 8'b1 << inst_i[14:12];

  // opcode bit groups
  wire op_1_0_11  = opcode[1] & opcode[0];
  wire op_6_5_00  = ~opcode[6] & ~opcode[5];
  wire op_6_5_01  = ~opcode[6] & opcode[5];
  wire op_6_5_11  = opcode[6] & opcode[5];
  wire op_4_2_000 = opcode[4:2] == 3'b000;
  wire op_4_2_001 = opcode[4:2] == 3'b001;
  wire op_4_2_011 = opcode[4:2] == 3'b011;
  wire op_4_2_100 = opcode[4:2] == 3'b100;
  wire op_4_2_101 = opcode[4:2] == 3'b101;
  wire op_4_2_110 = opcode[4:2] == 3'b110;

  // instruction groups
  wire grp_r     = op_6_5_01 & op_4_2_100 & op_1_0_11;
  wire grp_i     = op_6_5_00 & op_4_2_100 & op_1_0_11;
  wire grp_l     = op_6_5_00 & op_4_2_000 & op_1_0_11;
  wire grp_s     = op_6_5_01 & op_4_2_000 & op_1_0_11;
  wire grp_b     = op_6_5_11 & op_4_2_000 & op_1_0_11;
  wire grp_lui   = op_6_5_01 & op_4_2_101 & op_1_0_11;
  wire grp_auipc = op_6_5_00 & op_4_2_101 & op_1_0_11;
  wire grp_jal   = op_6_5_11 & op_4_2_011 & op_1_0_11;
  wire grp_jalr  = op_6_5_11 & op_4_2_001 & op_1_0_11;
  wire grp_sys   = op_6_5_11 & op_4_2_100 & op_1_0_11;
  wire grp_rw    = op_6_5_01 & op_4_2_110 & op_1_0_11;
  wire grp_iw    = op_6_5_00 & op_4_2_110 & op_1_0_11;

  wire f7_00 = funct7 == 7'h00;
  wire f7_20 = funct7 == 7'h20;
  // rv64 shifts by immediate take a 6-bit shamt
  wire f6_00 = inst_i[31:26] == 6'h00;
  wire f6_10 = inst_i[31:26] == 6'h10;

  // alu operations, register and immediate forms
  wire add_r = (grp_r | grp_rw) & f3[0] & f7_00;
  wire sub_r = (grp_r | grp_rw) & f3[0] & f7_20;
  wire sll_r = (grp_r | grp_rw) & f3[1] & f7_00;
  wire srl_r = (grp_r | grp_rw) & f3[5] & f7_00;
  wire sra_r = (grp_r | grp_rw) & f3[5] & f7_20;
  wire slt_r  = grp_r & f3[2] & f7_00;
  wire sltu_r = grp_r & f3[3] & f7_00;
  wire xor_r  = grp_r & f3[4] & f7_00;
  wire or_r   = grp_r & f3[6] & f7_00;
  wire and_r  = grp_r & f3[7] & f7_00;

  wire add_i = (grp_i | grp_iw) & f3[0];
  wire sll_i = (grp_i & f3[1] & f6_00) | (grp_iw & f3[1] & f7_00);
  wire srl_i = (grp_i & f3[5] & f6_00) | (grp_iw & f3[5] & f7_00);
  wire sra_i = (grp_i & f3[5] & f6_10) | (grp_iw & f3[5] & f7_20);
  wire slt_i  = grp_i & f3[2];
  wire sltu_i = grp_i & f3[3];
  wire xor_i  = grp_i & f3[4];
  wire or_i   = grp_i & f3[6];
  wire and_i  = grp_i & f3[7];

  // ebreak must match the full encoding
  wire ebreak = grp_sys & (inst_i[31:7] == {12'h001, 13'h0000});
  wire jal    = grp_jal;
  wire jalr   = grp_jalr & f3[0];
  wire br_op  = grp_b & (f3[0] | f3[1] | f3[4] | f3[5] | f3[6] | f3[7]);
  wire load   = grp_l & ~f3[7];
  wire store  = grp_s & (f3[0] | f3[1] | f3[2] | f3[3]);

  wire alu_add = add_r | add_i | grp_auipc;
  wire alu_sll = sll_r | sll_i;
  wire alu_srl = srl_r | srl_i;
  wire alu_sra = sra_r | sra_i;
  wire alu_wop = (grp_rw | grp_iw) & (alu_add | sub_r | alu_sll | alu_srl | alu_sra);
  wire alu_op  = alu_add | sub_r | alu_sll | slt_r | slt_i | sltu_r | sltu_i | xor_r |
                 xor_i | alu_srl | alu_sra | or_r | or_i | and_r | and_i | grp_lui | ebreak;
  wire bjp_op  = br_op | jal | jalr;
  wire ls_op   = load | store;

  // immediates
  wire [63:0] imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  wire [63:0] imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  wire [63:0] imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  wire [63:0] imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'h000};
  wire [63:0] imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  wire [`XLEN-1:0] imm = ({64{grp_i | grp_iw | grp_l | jalr}} & imm_i) |
                         ({64{grp_s}}                        & imm_s) |
                         ({64{grp_b}}                        & imm_b) |
                         ({64{jal}}                          & imm_j) |
                         ({64{grp_lui | grp_auipc}}          & imm_u);

  assign rd_idx_o  = inst_i[11:7];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  assign rd_wr_en_o    = (rd_idx_o != 5'd0) & ((alu_op & ~ebreak) | jal | jalr | load);
  assign rs1_read_en_o = (alu_op & ~(grp_lui | grp_auipc | ebreak)) | jalr | br_op | ls_op;
  assign rs2_read_en_o = (alu_op & (grp_r | grp_rw)) | br_op | store;

  // alu operands, jumps link through pc + 4
  wire op1_rs1 = alu_op & ~(grp_lui | grp_auipc | ebreak);
  wire op1_pc  = grp_auipc | jal | jalr;
  wire op2_rs2 = alu_op & (grp_r | grp_rw);
  wire op2_imm = (alu_op & (grp_i | grp_iw)) | grp_lui | grp_auipc;
  wire op2_four = jal | jalr;

  assign op1_o = ({64{op1_rs1}} & rs1_data_i) | ({64{op1_pc}} & pc_i);
  assign op2_o = ({64{op2_rs2}} & rs2_data_i) | ({64{op2_imm}} & imm) |
                 ({64{op2_four}} & 64'd4);

  // target and address operands
  assign op1_jp_o   = ({64{jalr | ls_op}} & rs1_data_i) | ({64{br_op | jal}} & pc_i);
  assign op2_jp_s_o = {64{bjp_op | ls_op}} & imm;

  always_comb begin
    exu_info_o = '0;
    if (alu_op) begin
      exu_info_o.alu.sel    = `EXU_SEL_ALU;
      exu_info_o.alu.add    = alu_add;
      exu_info_o.alu.sub    = sub_r;
      exu_info_o.alu.sll    = alu_sll;
      exu_info_o.alu.slt    = slt_r | slt_i;
      exu_info_o.alu.sltu   = sltu_r | sltu_i;
      exu_info_o.alu.xor_   = xor_r | xor_i;
      exu_info_o.alu.srl    = alu_srl;
      exu_info_o.alu.sra    = alu_sra;
      exu_info_o.alu.or_    = or_r | or_i;
      exu_info_o.alu.and_   = and_r | and_i;
      exu_info_o.alu.lui    = grp_lui;
      exu_info_o.alu.ebreak = ebreak;
      exu_info_o.alu.wop    = alu_wop;
    end else if (bjp_op) begin
      exu_info_o.bjp.sel  = `EXU_SEL_BJP;
      exu_info_o.bjp.jal  = jal;
      exu_info_o.bjp.jalr = jalr;
      exu_info_o.bjp.beq  = br_op & f3[0];
      exu_info_o.bjp.bne  = br_op & f3[1];
      exu_info_o.bjp.blt  = br_op & f3[4];
      exu_info_o.bjp.bge  = br_op & f3[5];
      exu_info_o.bjp.bltu = br_op & f3[6];
      exu_info_o.bjp.bgeu = br_op & f3[7];
    end else if (ls_op) begin
      exu_info_o.ls.sel      = `EXU_SEL_LS;
      exu_info_o.ls.load     = load;
      exu_info_o.ls.store    = store;
      exu_info_o.ls.usign    = load & f3[4] | load & f3[5] | load & f3[6];
      exu_info_o.ls.sz_byte  = f3[0] | f3[4];
      exu_info_o.ls.sz_half  = f3[1] | f3[5];
      exu_info_o.ls.sz_word  = f3[2] | f3[6];
      exu_info_o.ls.sz_dword = f3[3];
    end
  end

  assign invalid_inst_o = ~(alu_op | bjp_op | ls_op);

  // a legal instruction always names exactly one unit
  always_comb begin
    assert final ($isunknown(inst_i) || invalid_inst_o ||
                  ($onehot({alu_op, bjp_op, ls_op}) &&
                   exu_info_o.alu.sel inside {`EXU_SEL_ALU, `EXU_SEL_BJP, `EXU_SEL_LS}));
  end

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // alu view with one-hot operation flags above the unit code
  typedef struct packed {
    logic       wop;
    logic       ebreak;
    logic       lui;
    logic       and_;
    logic       or_;
    logic       sra;
    logic       srl;
    logic       xor_;
    logic       sltu;
    logic       slt;
    logic       sll;
    logic       sub;
    logic       add;
    logic [2:0] sel;
  } alu_info_t;

  // branch and jump view
  typedef struct packed {
    logic [4:0] pad;
    logic       bgeu;
    logic       bltu;
    logic       bge;
    logic       blt;
    logic       bne;
    logic       beq;
    logic       jalr;
    logic       jal;
    logic [2:0] sel;
  } bjp_info_t;

  // load/store view with one-hot access size
  typedef struct packed {
    logic [5:0] pad;
    logic       sz_dword;
    logic       sz_word;
    logic       sz_half;
    logic       sz_byte;
    logic       usign;
    logic       store;
    logic       load;
    logic [2:0] sel;
  } ls_info_t;

  // one decoded word, read through the view its unit code names
  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
    ls_info_t  ls;
  } exu_info_t;

endpackage

`default_nettype wire

// File: rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// architectural data width
`define XLEN 64

// first fetch address after reset
`define RESET_PC 64'h8000_0000

// unit codes in bits 2..0 of the execution info word
// code 0 means no unit is selected
`define EXU_SEL_ALU 3'd1
`define EXU_SEL_BJP 3'd2
`define EXU_SEL_LS  3'd3

`endif
